//--- logic/mfp_config.svh
/*
 build-time sizes for the peripheral
 the fifo depth must be a power of two, pointers wrap by overflow
 prescaler width must hold the largest divisor (200)
*/
`ifndef MFP_CONFIG_SVH
`define MFP_CONFIG_SVH

// entries in each serial link fifo
`define MFP_FIFO_DEPTH 8

// bits in the timer prescaler counter
`define MFP_PRESCALE_W 8

// vector register after reset, s-bit clear so no in-service tracking
`define MFP_VR_RESET 8'h40

`endif

//--- logic/mfp_reg_pkg.sv
/*
 cpu side view of the register file
 only the registers that exist in this design get an address name
 timer c/d and usart sync/ucr addresses read back as zero
*/
package mfp_reg_pkg;

	// 5-bit register numbers as seen on the cpu address lines
	typedef enum logic [4:0] {
		GPIP = 5'h00,
		AER  = 5'h01,
		DDR  = 5'h02,
		IERA = 5'h03,
		IERB = 5'h04,
		IPRA = 5'h05,
		IPRB = 5'h06,
		ISRA = 5'h07,
		ISRB = 5'h08,
		IMRA = 5'h09,
		IMRB = 5'h0A,
		VR   = 5'h0B,
		TACR = 5'h0C,
		TBCR = 5'h0D,
		TADR = 5'h0F,
		TBDR = 5'h10,
		RSR  = 5'h15,
		TSR  = 5'h16,
		UDR  = 5'h17
	} reg_addr_e;

	typedef logic [7:0] byte_t;

	// interrupt controller state handed to the read mux
	typedef struct packed {
		logic [15:0] ier;
		logic [15:0] ipr;
		logic [15:0] isr;
		logic [15:0] imr;
		byte_t       vr;
	} irq_regs_t;

endpackage

//--- logic/mfp_irq_pkg.sv
/*
 interrupt source numbers and timer prescale codes
 sources 4, 5, 9 and 11 belong to missing blocks and never go pending
*/
package mfp_irq_pkg;

	`include "mfp_config.svh"

	// bit positions in the 16-bit ier/ipr/imr/isr words
	typedef enum logic [3:0] {
		GPIP0    = 4'd0,
		GPIP1    = 4'd1,
		GPIP2    = 4'd2,
		GPIP3    = 4'd3,
		GPIP4    = 4'd6,
		GPIP5    = 4'd7,
		TIMER_B  = 4'd8,
		TX_EMPTY = 4'd10,
		RX_FULL  = 4'd12,
		TIMER_A  = 4'd13,
		GPIP6    = 4'd14,
		GPIP7    = 4'd15
	} irq_src_e;

	// low three bits of tacr/tbcr, delay mode only
	typedef enum logic [2:0] {
		STOP, DIV4, DIV10, DIV16, DIV50, DIV64, DIV100, DIV200
	} prescale_e;

	localparam int unsigned PRESCALE_W = `MFP_PRESCALE_W;

	// clock divisor for a prescale code, stop maps to 1 and is gated elsewhere
	function automatic logic [PRESCALE_W-1:0] prescale_div(input prescale_e p);
		logic [PRESCALE_W-1:0] d;
		case (p)
			DIV4:    d = PRESCALE_W'(4);
			DIV10:   d = PRESCALE_W'(10);
			DIV16:   d = PRESCALE_W'(16);
			DIV50:   d = PRESCALE_W'(50);
			DIV64:   d = PRESCALE_W'(64);
			DIV100:  d = PRESCALE_W'(100);
			DIV200:  d = PRESCALE_W'(200);
			default: d = PRESCALE_W'(1);
		endcase
		return d;
	endfunction

endpackage

//--- logic/mfp_bus_if.sv
/*
 decoded register access, valid for the one cycle of the cpu access
 sinks compare addr against their own registers
*/
interface mfp_bus_if;

	// write strobe, sel and ds qualified
	logic wr_o;
	// read strobe, same qualification
	logic rd_o;
	mfp_reg_pkg::reg_addr_e addr;
	mfp_reg_pkg::byte_t wdata;

	// decoder drives the access
	modport dec (output wr_o, rd_o, addr, wdata);

	// timers and interrupt controller only listen
	modport sink (input wr_o, rd_o, addr, wdata);

endinterface

//--- logic/io_fifo.sv
/*
 single clock byte fifo for the io controller link
 push while full is dropped, pop while empty is ignored
 data_o shows the head entry combinationally
*/
module io_fifo (
	input  logic               clk,
	input  logic               reset,
	input  logic               push_i,
	input  mfp_reg_pkg::byte_t data_i,
	input  logic               pop_i,
	output mfp_reg_pkg::byte_t data_o,
	output logic               full_o,
	output logic               avail_o
);

	`include "mfp_config.svh"

	localparam int unsigned AW = $clog2(`MFP_FIFO_DEPTH);
	localparam logic [AW:0] FULL_CNT = (AW+1)'(`MFP_FIFO_DEPTH);

	mfp_reg_pkg::byte_t mem [`MFP_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic push_ok;
	logic pop_ok;

	assign full_o = (count == FULL_CNT);
	assign avail_o = (count != '0);
	assign push_ok = push_i && !full_o;
	assign pop_ok = pop_i && avail_o;
	assign data_o = mem[rd_ptr];

	// pointers wrap on overflow, depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push_ok && !pop_ok) begin
				count <= count + 1'b1;
			end else if (pop_ok && !push_ok) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= data_i;
		end
	end

	a_count_bound: assert property (
		@(posedge clk) disable iff (reset) count <= FULL_CNT
	) else $error("fifo count above depth");

endmodule

//--- logic/mfp_timer.sv
/*
 one 8-bit timer in delay mode, prescaler counts clk
 reload value 0 gives 256 counts, data writes load the counter only while stopped
 t_i is synchronised and shown in ctrl bit 7, it gates nothing yet
*/
module mfp_timer #(
	parameter mfp_reg_pkg::reg_addr_e CTRL_ADDR = mfp_reg_pkg::TACR,
	parameter mfp_reg_pkg::reg_addr_e DATA_ADDR = mfp_reg_pkg::TADR
) (
	input  logic               clk,
	input  logic               reset,
	mfp_bus_if.sink            bus,
	input  logic               t_i,
	output logic               done_o,
	output mfp_reg_pkg::byte_t ctrl_o,
	output mfp_reg_pkg::byte_t count_o
);

	`include "mfp_config.svh"

	mfp_irq_pkg::prescale_e mode;
	logic [`MFP_PRESCALE_W-1:0] presc;
	logic [`MFP_PRESCALE_W-1:0] div;
	mfp_reg_pkg::byte_t reload;
	mfp_reg_pkg::byte_t count;
	logic [1:0] t_sync;
	logic ctrl_we;
	logic data_we;
	logic running;
	logic tick;

	assign ctrl_we = bus.wr_o && (bus.addr == CTRL_ADDR);
	assign data_we = bus.wr_o && (bus.addr == DATA_ADDR);
	assign running = (mode != mfp_irq_pkg::STOP);
	assign div = mfp_irq_pkg::prescale_div(mode);

	// a control write restarts the prescaler, so no tick in that cycle
	assign tick = running && !ctrl_we && (presc == div - 1'b1);

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= mfp_irq_pkg::STOP;
			presc <= '0;
			count <= '0;
			done_o <= 1'b0;
			t_sync <= '0;
		end else begin
			t_sync <= {t_sync[0], t_i};
			// one-cycle pulse after the tick that expires the count
			done_o <= tick && (count == 8'd1);
			if (ctrl_we) begin
				mode <= mfp_irq_pkg::prescale_e'(bus.wdata[2:0]);
				presc <= '0;
			end else if (tick) begin
				presc <= '0;
			end else if (running) begin
				presc <= presc + 1'b1;
			end
			if (data_we && !running) begin
				count <= bus.wdata;
			end else if (tick) begin
				// 0 wraps to 255 here, giving 256 counts
				count <= (count == 8'd1) ? reload : count - 1'b1;
			end
		end
	end

	// reload value is kept across stop and restart
	always_ff @(posedge clk) begin
		if (data_we) begin
			reload <= bus.wdata;
		end
	end

	assign ctrl_o = {t_sync[1], 4'b0000, mode};
	assign count_o = count;

	a_done_single: assert property (
		@(posedge clk) disable iff (reset) done_o |=> !done_o
	) else $error("timer done held for two cycles");

endmodule

//--- logic/mfp_irq_ctrl.sv
/*
 16-source interrupt controller
 gpio events are edge sensitive, aer bit 1 selects the rising edge
 timer c/d and usart error sources are absent, their bits never go pending
 isr tracking only when vr bit 3 is set
*/
module mfp_irq_ctrl (
	input  logic                   clk,
	input  logic                   reset,
	mfp_bus_if.sink                bus,
	input  mfp_reg_pkg::byte_t     gpio_i,
	input  mfp_reg_pkg::byte_t     aer_i,
	input  logic                   timer_a_done_i,
	input  logic                   timer_b_done_i,
	input  logic                   tx_full_i,
	input  logic                   rx_avail_i,
	input  logic                   iack_i,
	output logic                   irq_o,
	output mfp_reg_pkg::byte_t     vec_o,
	output mfp_reg_pkg::irq_regs_t irq_regs_o
);

	`include "mfp_config.svh"

	logic [15:0] ier, ipr, imr, isr;
	logic [15:0] ier_nxt, ipr_nxt, imr_nxt, isr_nxt;
	mfp_reg_pkg::byte_t vr, vr_nxt;
	mfp_reg_pkg::byte_t gpio_d1, gpio_d2;
	mfp_reg_pkg::byte_t vec_q;
	logic [7:0] gpio_fall;
	logic [15:0] events;
	logic [15:0] pending;
	logic [3:0] top_pending;
	logic [3:0] top_service;
	logic tx_full_d, rx_avail_d, iack_d;
	logic ack_start;

	// index of the highest set bit, 0 when empty
	function automatic logic [3:0] top_bit(input logic [15:0] v);
		logic [3:0] idx;
		idx = 4'd0;
		for (int b = 0; b < 16; b++) begin
			if (v[b]) begin
				idx = 4'(b);
			end
		end
		return idx;
	endfunction

	// two stage input delay with polarity applied up front
	always_ff @(posedge clk) begin
		if (reset) begin
			gpio_d1 <= '0;
			gpio_d2 <= '0;
			tx_full_d <= 1'b0;
			rx_avail_d <= 1'b0;
			iack_d <= 1'b0;
		end else begin
			gpio_d1 <= gpio_i ^ aer_i;
			gpio_d2 <= gpio_d1;
			tx_full_d <= tx_full_i;
			rx_avail_d <= rx_avail_i;
			iack_d <= iack_i;
		end
	end

	assign gpio_fall = gpio_d2 & ~gpio_d1;
	assign ack_start = iack_i && !iack_d;
	assign pending = ipr & imr;
	assign top_pending = top_bit(pending);
	assign top_service = top_bit(isr);

	// map event sources onto their interrupt numbers
	always_comb begin
		events = '0;
		events[mfp_irq_pkg::GPIP0] = gpio_fall[0];
		events[mfp_irq_pkg::GPIP1] = gpio_fall[1];
		events[mfp_irq_pkg::GPIP2] = gpio_fall[2];
		events[mfp_irq_pkg::GPIP3] = gpio_fall[3];
		events[mfp_irq_pkg::GPIP4] = gpio_fall[4];
		events[mfp_irq_pkg::GPIP5] = gpio_fall[5];
		events[mfp_irq_pkg::GPIP6] = gpio_fall[6];
		events[mfp_irq_pkg::GPIP7] = gpio_fall[7];
		events[mfp_irq_pkg::TIMER_A] = timer_a_done_i;
		events[mfp_irq_pkg::TIMER_B] = timer_b_done_i;
		// outbound fifo left the full state
		events[mfp_irq_pkg::TX_EMPTY] = tx_full_d && !tx_full_i;
		// inbound fifo just got its first byte
		events[mfp_irq_pkg::RX_FULL] = !rx_avail_d && rx_avail_i;
	end

	// acknowledge first, then new events, then cpu writes win
	always_comb begin
		ier_nxt = ier;
		ipr_nxt = ipr;
		imr_nxt = imr;
		isr_nxt = isr;
		vr_nxt = vr;
		if (ack_start && (|pending)) begin
			ipr_nxt[top_pending] = 1'b0;
			if (vr[3]) begin
				isr_nxt[top_pending] = 1'b1;
			end
		end
		ipr_nxt = ipr_nxt | (events & ier);
		if (bus.wr_o) begin
			case (bus.addr)
				// disabling a source also drops its pending bit
				mfp_reg_pkg::IERA: begin
					ier_nxt[15:8] = bus.wdata;
					ipr_nxt[15:8] = ipr_nxt[15:8] & bus.wdata;
				end
				mfp_reg_pkg::IERB: begin
					ier_nxt[7:0] = bus.wdata;
					ipr_nxt[7:0] = ipr_nxt[7:0] & bus.wdata;
				end
				// zero bits clear, one bits leave alone
				mfp_reg_pkg::IPRA: ipr_nxt[15:8] = ipr_nxt[15:8] & bus.wdata;
				mfp_reg_pkg::IPRB: ipr_nxt[7:0] = ipr_nxt[7:0] & bus.wdata;
				mfp_reg_pkg::ISRA: isr_nxt[15:8] = isr_nxt[15:8] & bus.wdata;
				mfp_reg_pkg::ISRB: isr_nxt[7:0] = isr_nxt[7:0] & bus.wdata;
				mfp_reg_pkg::IMRA: imr_nxt[15:8] = bus.wdata;
				mfp_reg_pkg::IMRB: imr_nxt[7:0] = bus.wdata;
				mfp_reg_pkg::VR:   vr_nxt = bus.wdata;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ier <= '0;
			ipr <= '0;
			imr <= '0;
			isr <= '0;
			vr <= `MFP_VR_RESET;
		end else begin
			ier <= ier_nxt;
			ipr <= ipr_nxt;
			imr <= imr_nxt;
			isr <= isr_nxt;
			vr <= vr_nxt;
		end
	end

	// vector frozen for the whole acknowledge cycle
	always_ff @(posedge clk) begin
		if (!iack_i) begin
			vec_q <= {vr[7:4], top_pending};
		end
	end

	// same level as in-service still interrupts
	assign irq_o = (|pending) && (top_pending >= top_service);
	assign vec_o = vec_q;
	assign irq_regs_o = '{ier: ier, ipr: ipr, isr: isr, imr: imr, vr: vr};

	a_vec_stable: assert property (
		@(posedge clk) disable iff (reset) iack_i ##1 iack_i |-> $stable(vec_o)
	) else $error("vector changed during iack");

endmodule

//--- logic/mfp_bus_decode.sv
/*
 cpu access decode and read mux
 accesses last one clock, ds is active low, rw high means read
 gpip has no output drivers, ddr only steers read-back
*/
module mfp_bus_decode (
	input  logic                   clk,
	input  logic                   reset,
	input  mfp_reg_pkg::byte_t     din_i,
	input  logic                   sel_i,
	input  logic [4:0]             addr_i,
	input  logic                   ds_i,
	input  logic                   rw_i,
	output mfp_reg_pkg::byte_t     dout_o,
	input  logic                   iack_i,
	mfp_bus_if.dec                 bus,
	input  mfp_reg_pkg::byte_t     gpio_i,
	input  mfp_reg_pkg::byte_t     tacr_i,
	input  mfp_reg_pkg::byte_t     tbcr_i,
	input  mfp_reg_pkg::byte_t     tadr_i,
	input  mfp_reg_pkg::byte_t     tbdr_i,
	input  mfp_reg_pkg::irq_regs_t irq_regs_i,
	input  mfp_reg_pkg::byte_t     vec_i,
	input  mfp_reg_pkg::byte_t     rx_data_i,
	input  logic                   rx_avail_i,
	input  logic                   tx_full_i,
	output logic                   tx_push_o,
	output logic                   rx_pop_o,
	output mfp_reg_pkg::byte_t     aer_o
);

	mfp_reg_pkg::byte_t gpip;
	mfp_reg_pkg::byte_t aer;
	mfp_reg_pkg::byte_t ddr;
	logic [1:0] rsr_ctrl;
	logic [3:0] tsr_ctrl;
	logic access;

	assign access = sel_i && !ds_i;
	assign bus.wr_o = access && !rw_i;
	assign bus.rd_o = access && rw_i;
	assign bus.addr = mfp_reg_pkg::reg_addr_e'(addr_i);
	assign bus.wdata = din_i;

	// udr write feeds the outbound fifo, udr read pops the inbound head
	assign tx_push_o = bus.wr_o && (bus.addr == mfp_reg_pkg::UDR);
	assign rx_pop_o = bus.rd_o && (bus.addr == mfp_reg_pkg::UDR);
	assign aer_o = aer;

	// port and usart control registers
	always_ff @(posedge clk) begin
		if (reset) begin
			gpip <= '0;
			aer <= '0;
			ddr <= '0;
			rsr_ctrl <= '0;
			tsr_ctrl <= '0;
		end else if (bus.wr_o) begin
			case (bus.addr)
				mfp_reg_pkg::GPIP: gpip <= din_i;
				mfp_reg_pkg::AER:  aer <= din_i;
				mfp_reg_pkg::DDR:  ddr <= din_i;
				mfp_reg_pkg::RSR:  rsr_ctrl <= din_i[1:0];
				mfp_reg_pkg::TSR:  tsr_ctrl <= din_i[3:0];
				default: ;
			endcase
		end
	end

	// read mux, vector only when the cpu is not selecting a register
	always_comb begin
		dout_o = '0;
		if (bus.rd_o) begin
			case (bus.addr)
				// ddr bit set means pin is an output, show the latch
				mfp_reg_pkg::GPIP: dout_o = (gpio_i & ~ddr) | (gpip & ddr);
				mfp_reg_pkg::AER:  dout_o = aer;
				mfp_reg_pkg::DDR:  dout_o = ddr;
				mfp_reg_pkg::IERA: dout_o = irq_regs_i.ier[15:8];
				mfp_reg_pkg::IERB: dout_o = irq_regs_i.ier[7:0];
				mfp_reg_pkg::IPRA: dout_o = irq_regs_i.ipr[15:8];
				mfp_reg_pkg::IPRB: dout_o = irq_regs_i.ipr[7:0];
				mfp_reg_pkg::ISRA: dout_o = irq_regs_i.isr[15:8];
				mfp_reg_pkg::ISRB: dout_o = irq_regs_i.isr[7:0];
				mfp_reg_pkg::IMRA: dout_o = irq_regs_i.imr[15:8];
				mfp_reg_pkg::IMRB: dout_o = irq_regs_i.imr[7:0];
				mfp_reg_pkg::VR:   dout_o = irq_regs_i.vr;
				mfp_reg_pkg::TACR: dout_o = tacr_i;
				mfp_reg_pkg::TBCR: dout_o = tbcr_i;
				mfp_reg_pkg::TADR: dout_o = tadr_i;
				mfp_reg_pkg::TBDR: dout_o = tbdr_i;
				// buffer full flag in bit 7
				mfp_reg_pkg::RSR:  dout_o = {rx_avail_i, 5'b00000, rsr_ctrl};
				// tx buffer empty means room in the fifo
				mfp_reg_pkg::TSR:  dout_o = {!tx_full_i, 3'b000, tsr_ctrl};
				mfp_reg_pkg::UDR:  dout_o = rx_data_i;
				default:           dout_o = '0;
			endcase
		end else if (iack_i) begin
			dout_o = vec_i;
		end
	end

	// the cpu never runs a register access inside an acknowledge cycle
	a_no_access_in_iack: assert property (
		@(posedge clk) disable iff (reset) iack_i |-> !access
	) else $error("register access during iack");

endmodule

//--- logic/mfp.sv
/*
 mfp top level, 68000-style register bus at 5-bit addresses
 one-clock accesses sampled at the rising edge, ds active low
 timers a and b in delay mode only, no serial shifter or gpip drivers
*/
module mfp (
	input  logic               clk,
	input  logic               reset,
	input  mfp_reg_pkg::byte_t din_i,
	input  logic               sel_i,
	input  logic [4:0]         addr_i,
	input  logic               ds_i,
	input  logic               rw_i,
	output mfp_reg_pkg::byte_t dout_o,
	output logic               irq_o,
	input  logic               iack_i,
	output logic               serial_data_out_available_o,
	input  logic               serial_strobe_out_i,
	output mfp_reg_pkg::byte_t serial_data_out_o,
	input  logic               serial_strobe_in_i,
	input  mfp_reg_pkg::byte_t serial_data_in_i,
	output logic               serial_data_in_full_o,
	input  logic [1:0]         t_i,
	input  mfp_reg_pkg::byte_t gpio_i
);

	mfp_bus_if bus ();

	mfp_reg_pkg::byte_t tacr, tbcr, tadr, tbdr;
	mfp_reg_pkg::byte_t vec, aer, rx_data;
	mfp_reg_pkg::irq_regs_t irq_regs;
	logic timer_a_done, timer_b_done;
	logic tx_full, tx_push, rx_pop, rx_avail;

	mfp_bus_decode u_decode (
		.clk, .reset, .din_i, .sel_i, .addr_i, .ds_i, .rw_i, .dout_o, .iack_i,
		.bus (bus.dec), .gpio_i,
		.tacr_i (tacr), .tbcr_i (tbcr), .tadr_i (tadr), .tbdr_i (tbdr),
		.irq_regs_i (irq_regs), .vec_i (vec),
		.rx_data_i (rx_data), .rx_avail_i (rx_avail), .tx_full_i (tx_full),
		.tx_push_o (tx_push), .rx_pop_o (rx_pop), .aer_o (aer)
	);

	mfp_timer #(.CTRL_ADDR(mfp_reg_pkg::TACR), .DATA_ADDR(mfp_reg_pkg::TADR)) timer_a (
		.clk, .reset, .bus (bus.sink), .t_i (t_i[0]),
		.done_o (timer_a_done), .ctrl_o (tacr), .count_o (tadr)
	);

	mfp_timer #(.CTRL_ADDR(mfp_reg_pkg::TBCR), .DATA_ADDR(mfp_reg_pkg::TBDR)) timer_b (
		.clk, .reset, .bus (bus.sink), .t_i (t_i[1]),
		.done_o (timer_b_done), .ctrl_o (tbcr), .count_o (tbdr)
	);

	mfp_irq_ctrl u_irq (
		.clk, .reset, .bus (bus.sink), .gpio_i, .aer_i (aer),
		.timer_a_done_i (timer_a_done), .timer_b_done_i (timer_b_done),
		.tx_full_i (tx_full), .rx_avail_i (rx_avail), .iack_i,
		.irq_o, .vec_o (vec), .irq_regs_o (irq_regs)
	);

	// cpu writes udr, io controller drains
	io_fifo fifo_out (
		.clk, .reset, .push_i (tx_push), .data_i (din_i),
		.pop_i (serial_strobe_out_i), .data_o (serial_data_out_o),
		.full_o (tx_full), .avail_o (serial_data_out_available_o)
	);

	// io controller fills, cpu reads udr
	io_fifo fifo_in (
		.clk, .reset, .push_i (serial_strobe_in_i), .data_i (serial_data_in_i),
		.pop_i (rx_pop), .data_o (rx_data),
		.full_o (serial_data_in_full_o), .avail_o (rx_avail)
	);

endmodule

//--- tests/tb_mfp.sv
/*
 testbench for the mfp top level, driven line by line from tests/mfp_stimulus.txt
 run from the project root so the stimulus path resolves
 one bus, port or link operation per line, the first mismatch ends the run
*/
module tb_mfp;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_HALF = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 5;
	// stimulus takes roughly 250 cycles, limit leaves a wide margin
	localparam int MAX_CYCLES = 2000;
	localparam string STIM_FILE = "tests/mfp_stimulus.txt";

	logic clk;
	logic reset;
	logic [7:0] din_i;
	logic sel_i;
	logic [4:0] addr_i;
	logic ds_i;
	logic rw_i;
	logic [7:0] dout_o;
	logic irq_o;
	logic iack_i;
	logic serial_data_out_available_o;
	logic serial_strobe_out_i;
	logic [7:0] serial_data_out_o;
	logic serial_strobe_in_i;
	logic [7:0] serial_data_in_i;
	logic serial_data_in_full_o;
	logic [1:0] t_i;
	logic [7:0] gpio_i;

	int cycle_count = 0;
	int fail_count = 0;
	int line_no = 0;

	mfp DUT (.*);

	always #(CLK_HALF) clk = ~clk;

	task automatic report_mismatch(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		fail_count++;
		$display("Fail %s got %h expected %h at stimulus line %0d",
			name, got, exp, line_no);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic report_problem(input string what);
		fail_count++;
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped on a testbench error");
	endtask

	// hung run guard
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			report_problem($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
		end
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else report_mismatch(name, got, exp);
	endtask

	// start of a new cycle, all strobes back to idle
	task automatic next_slot();
		@(posedge clk);
		#(DRIVE_DELAY);
		sel_i = 1'b0;
		ds_i = 1'b1;
		rw_i = 1'b1;
		iack_i = 1'b0;
		serial_strobe_out_i = 1'b0;
		serial_strobe_in_i = 1'b0;
	endtask

	// write lands at the edge that closes this cycle
	task automatic bus_write(input logic [4:0] addr, input logic [7:0] data);
		next_slot();
		sel_i = 1'b1;
		ds_i = 1'b0;
		rw_i = 1'b0;
		addr_i = addr;
		din_i = data;
	endtask

	// read data is combinational, sampled mid cycle
	task automatic bus_read(input logic [4:0] addr, input logic [7:0] exp);
		next_slot();
		sel_i = 1'b1;
		ds_i = 1'b0;
		rw_i = 1'b1;
		addr_i = addr;
		@(negedge clk);
		check_byte("dout_o", dout_o, exp);
	endtask

	task automatic set_gpio(input logic [7:0] pins, input logic [7:0] exp_irq);
		next_slot();
		gpio_i = pins;
		@(negedge clk);
		check_byte("irq_o", {7'd0, irq_o}, exp_irq);
	endtask

	// irq checked in the last idle cycle
	task automatic idle_cycles(input logic [7:0] cycles, input logic [7:0] exp_irq);
		repeat (cycles) next_slot();
		@(negedge clk);
		check_byte("irq_o", {7'd0, irq_o}, exp_irq);
	endtask

	// vector shown during the acknowledge cycle, irq checked one cycle later
	task automatic interrupt_ack(input logic [7:0] exp_vec, input logic [7:0] exp_irq);
		next_slot();
		iack_i = 1'b1;
		@(negedge clk);
		check_byte("dout_o", dout_o, exp_vec);
		next_slot();
		@(negedge clk);
		check_byte("irq_o", {7'd0, irq_o}, exp_irq);
	endtask

	task automatic serial_push(input logic [7:0] data, input logic [7:0] exp_full);
		next_slot();
		serial_strobe_in_i = 1'b1;
		serial_data_in_i = data;
		next_slot();
		@(negedge clk);
		check_byte("serial_data_in_full_o", {7'd0, serial_data_in_full_o}, exp_full);
	endtask

	// head byte must be valid before the pop, flag checked after it
	task automatic serial_pop(input logic [7:0] exp_data, input logic [7:0] exp_avail);
		next_slot();
		serial_strobe_out_i = 1'b1;
		@(negedge clk);
		check_byte("serial_data_out_available_o", {7'd0, serial_data_out_available_o}, 8'h01);
		check_byte("serial_data_out_o", serial_data_out_o, exp_data);
		next_slot();
		@(negedge clk);
		check_byte("serial_data_out_available_o", {7'd0, serial_data_out_available_o},
			exp_avail);
	endtask

	initial begin
		int fd;
		int fields;
		int got_line;
		logic [8*96-1:0] line_buf;
		string op_word;
		logic [7:0] arg_a;
		logic [7:0] arg_b;
		clk = 1'b0;
		reset = 1'b1;
		din_i = '0;
		sel_i = 1'b0;
		addr_i = '0;
		ds_i = 1'b1;
		rw_i = 1'b1;
		iack_i = 1'b0;
		serial_strobe_out_i = 1'b0;
		serial_strobe_in_i = 1'b0;
		serial_data_in_i = '0;
		t_i = '0;
		gpio_i = '0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			report_problem("could not open the stimulus file");
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		reset = 1'b0;
		while (!$feof(fd)) begin
			line_buf = '0;
			got_line = $fgets(line_buf, fd);
			line_no++;
			fields = $sscanf(line_buf, "%s %h %h", op_word, arg_a, arg_b);
			// blank lines and comment lines
			if (got_line == 0 || fields <= 0 || op_word == "#") begin
				continue;
			end
			if (fields != 3) begin
				report_problem($sformatf("stimulus line %0d is malformed", line_no));
			end
			case (op_word)
				"WR":    bus_write(arg_a[4:0], arg_b);
				"RD":    bus_read(arg_a[4:0], arg_b);
				"GPIO":  set_gpio(arg_a, arg_b);
				"WAIT":  idle_cycles(arg_a, arg_b);
				"IACK":  interrupt_ack(arg_a, arg_b);
				"SPUSH": serial_push(arg_a, arg_b);
				"SPOP":  serial_pop(arg_a, arg_b);
				default: report_problem($sformatf("unknown opcode %s on stimulus line %0d",
					op_word, line_no));
			endcase
		end
		$fclose(fd);
		next_slot();
		next_slot();
		if (fail_count == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "checks failed");
		end
	end

endmodule

//--- tests/mfp_stimulus.txt
# columns: opcode, operand a, operand b, every number in hex (WAIT counts too)
# WR reg data | RD reg expect | GPIO pins irq | WAIT cycles irq | IACK vector irq
# SPUSH data full | SPOP data avail
# reset values
RD 0B 40
RD 03 00
WAIT 01 00
# port registers and gpip read-back merge
GPIO 3C 00
WR 02 F0
RD 02 F0
WR 01 0F
RD 01 0F
WR 00 A5
RD 00 AC
WR 01 00
WR 02 00
GPIO 00 00
WAIT 03 00
# gpip0 falling edge, then rising edge with aer set
WR 04 01
WR 0A 01
GPIO 01 00
WAIT 03 00
RD 06 00
GPIO 00 00
WAIT 02 01
RD 06 01
WR 06 00
WAIT 01 00
WR 01 01
WAIT 03 00
GPIO 01 00
WAIT 02 01
RD 06 01
WR 06 00
GPIO 00 00
WAIT 03 00
RD 06 00
# disabled source stays idle
WR 04 00
WR 01 00
GPIO 01 00
GPIO 00 00
WAIT 03 00
RD 06 00
# priority between gpip0 and timer a, in-service tracking on
WR 0B 48
WR 04 01
GPIO 01 00
WAIT 03 00
GPIO 00 00
WAIT 03 01
WR 03 20
WR 09 20
WR 0F 01
WR 0C 01
WAIT 06 01
WR 0C 00
RD 05 20
RD 06 01
IACK 4D 00
RD 07 20
RD 05 00
WR 07 00
IACK 40 00
RD 08 01
WR 08 00
WR 0B 40
WR 04 00
WR 0A 00
# timer a reload 3, divide by 4
WR 0F 03
WR 0C 01
WAIT 0C 00
RD 05 00
RD 05 20
WAIT 01 01
WR 0C 00
WR 05 DF
WAIT 1E 00
RD 05 00
WR 03 00
WR 09 00
# outbound link
RD 16 80
WR 17 11
WR 17 22
WR 17 33
WR 17 44
WR 17 55
WR 17 66
WR 17 77
WR 17 88
RD 16 00
SPOP 11 01
SPOP 22 01
SPOP 33 01
SPOP 44 01
SPOP 55 01
SPOP 66 01
SPOP 77 01
SPOP 88 00
RD 16 80
# inbound link, ninth byte dropped
RD 15 00
WR 03 10
WR 09 10
SPUSH 01 00
SPUSH 02 00
SPUSH 03 00
SPUSH 04 00
SPUSH 05 00
SPUSH 06 00
SPUSH 07 00
SPUSH 08 01
SPUSH 99 01
RD 05 10
WAIT 01 01
RD 15 80
RD 17 01
RD 17 02
RD 17 03
RD 17 04
RD 17 05
RD 17 06
RD 17 07
RD 17 08
RD 15 00
WR 05 00
WAIT 01 00

//--- sources.f
+incdir+logic
logic/mfp_reg_pkg.sv
logic/mfp_irq_pkg.sv
logic/mfp_bus_if.sv
logic/io_fifo.sv
logic/mfp_timer.sv
logic/mfp_irq_ctrl.sv
logic/mfp_bus_decode.sv
logic/mfp.sv
tests/tb_mfp.sv

//--- Makefile
# Verilator build and run for the mfp testbench

VERILATOR ?= verilator
TOP ?= tb_mfp
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
STIMULUS ?= tests/mfp_stimulus.txt
PASS_MSG ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard logic/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(OBJ_DIR)/V%: $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* --Mdir $(OBJ_DIR)

run: $(BIN) $(STIMULUS)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
